// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // ------------------------------------------------------------------
  // bit timing
  // ------------------------------------------------------------------
  localparam int CLKS_PER_BIT = 16;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;  // mid-bit sample point.
  localparam int RESP_TIMEOUT = 64 * CLKS_PER_BIT;

  // ------------------------------------------------------------------
  // command fields
  // ------------------------------------------------------------------
  localparam int CMD_W  = 16;
  localparam int DATA_W = 8;
  localparam int RW_BIT = 15;  // set means write.

  typedef logic [CMD_W-1:0]                  cmd_word_t;
  typedef logic [DATA_W-1:0]                 data_byte_t;
  typedef logic [$clog2(CLKS_PER_BIT)-1:0]   baud_cnt_t;
  typedef logic [3:0]                        bit_idx_t;
  typedef logic [$clog2(RESP_TIMEOUT)-1:0]   tmo_cnt_t;

  // frame positions counted from the start bit at index 0.
  localparam bit_idx_t PAR_IDX  = 4'd9;
  localparam bit_idx_t STOP_IDX = 4'd10;

  typedef enum logic [2:0] {IDLE, SEND_LO, SEND_HI, WAIT_RESP, RECV, REPORT} seq_state_t;

endpackage

// ==== logic/serial_byte_if.sv ====
interface serial_byte_if import uart_cmd_pkg::*; ();

  // transmit side.
  data_byte_t tx_data;
  logic       tx_start;
  logic       tx_done;

  // receive side.
  logic       rx_arm;
  data_byte_t rx_data;
  logic       rx_valid;
  logic       rx_err;
  logic       rx_busy;

  modport seq (
    output tx_data, tx_start, rx_arm,
    input  tx_done, rx_data, rx_valid, rx_err, rx_busy
  );

  modport tx (
    input  tx_data, tx_start,
    output tx_done
  );

  modport rx (
    input  rx_arm,
    output rx_data, rx_valid, rx_err, rx_busy
  );

endinterface

// ==== logic/uart_tx_framer.sv ====
module uart_tx_framer import uart_cmd_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  serial_byte_if.tx link,
  output logic      tx
);

  logic       busy;
  logic       bit_end;
  logic       can_start;
  logic       load;
  baud_cnt_t  baud_cnt;
  bit_idx_t   bit_idx;
  bit_idx_t   next_idx;
  data_byte_t shift_q;
  logic       parity_q;

  assign bit_end  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
  assign next_idx = bit_idx + 1'b1;

  assign link.tx_done = busy && bit_end && (bit_idx == STOP_IDX);

  // the last stop cycle may already take the next byte.
  assign can_start = !busy || link.tx_done;
  assign load      = link.tx_start && can_start;

  // ------------------------------------------------------------------
  // bit sequencing
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (load)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b0;  // start bit.
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        bit_idx  <= next_idx;
        if (next_idx < PAR_IDX)
          tx <= shift_q[0];
        else if (next_idx == PAR_IDX)
          tx <= parity_q;
        else
          tx <= 1'b1;  // stop bit, then line idle.
        if (bit_idx == STOP_IDX)
          busy <= 1'b0;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // byte and parity registers. lsb leaves first.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shift_q  <= link.tx_data;
      parity_q <= ~^link.tx_data;  // odd.
    end
    else if (busy && bit_end && (next_idx < PAR_IDX))
      shift_q <= shift_q >> 1;
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> tx);

  a_start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    link.tx_start |-> can_start);

endmodule

// ==== logic/uart_rx_deframer.sv ====
module uart_rx_deframer import uart_cmd_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  serial_byte_if.rx link,
  input  logic      rx
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       fall;
  logic       busy;
  logic       sample;
  baud_cnt_t  baud_cnt;
  baud_cnt_t  sample_pt;
  bit_idx_t   bit_idx;
  data_byte_t shift_q;
  logic       par_ok;
  logic       rx_valid_q;
  logic       rx_err_q;

  // ------------------------------------------------------------------
  // line synchronizer and start edge
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // start bit is checked at half a bit, the rest at full bit steps.
  assign sample_pt = (bit_idx == '0) ? baud_cnt_t'(HALF_BIT - 1)
                                     : baud_cnt_t'(CLKS_PER_BIT - 1);
  assign sample    = busy && (baud_cnt == sample_pt);

  // ------------------------------------------------------------------
  // frame control
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy       <= 1'b0;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      rx_valid_q <= 1'b0;
    end
    else
    begin
      rx_valid_q <= 1'b0;
      if (!busy)
      begin
        if (link.rx_arm && fall)
        begin
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (!link.rx_arm)
        busy <= 1'b0;
      else if (sample)
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if ((bit_idx == '0) && rx_sync)
          busy <= 1'b0;  // glitch, not a start bit.
        else if (bit_idx == STOP_IDX)
        begin
          busy       <= 1'b0;
          rx_valid_q <= 1'b1;
        end
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if ((bit_idx != '0) && (bit_idx < PAR_IDX))
        shift_q <= {rx_sync, shift_q[DATA_W-1:1]};
      if (bit_idx == PAR_IDX)
        par_ok <= ^{shift_q, rx_sync};  // odd count of ones.
      if (bit_idx == STOP_IDX)
        rx_err_q <= !par_ok || !rx_sync;
    end
  end

  assign link.rx_data  = shift_q;
  assign link.rx_valid = rx_valid_q;
  assign link.rx_err   = rx_err_q;
  assign link.rx_busy  = busy;

  a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    link.rx_valid |=> !link.rx_valid);

endmodule

// ==== logic/cmd_sequencer.sv ====
module cmd_sequencer import uart_cmd_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  cmd_word_t     cmd_in,
  input  logic          cmd_vld,
  output logic          cmd_rdy,
  output data_byte_t    read_data,
  output logic          read_rdy,
  output logic          read_err,
  serial_byte_if.seq    link
);

  seq_state_t state;
  cmd_word_t  cmd_q;
  tmo_cnt_t   tmo_cnt;
  logic       start_lo;
  logic       rx_arm_q;
  logic       accept;
  logic       timeout_hit;
  logic       resp_done;

  assign accept      = cmd_vld && cmd_rdy;
  assign timeout_hit = (state == WAIT_RESP) && !link.rx_busy
                       && (tmo_cnt == tmo_cnt_t'(RESP_TIMEOUT - 1));
  assign resp_done   = (state == RECV) && link.rx_valid;

  // ------------------------------------------------------------------
  // byte ordering towards the framer
  // ------------------------------------------------------------------
  // high byte is handed over in the stop cycle of the low byte.
  assign link.tx_start = start_lo || ((state == SEND_LO) && link.tx_done);
  assign link.tx_data  = start_lo ? cmd_q[DATA_W-1:0] : cmd_q[CMD_W-1:DATA_W];
  assign link.rx_arm   = rx_arm_q;

  // ------------------------------------------------------------------
  // command FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      cmd_rdy  <= 1'b1;
      read_rdy <= 1'b0;
      start_lo <= 1'b0;
      rx_arm_q <= 1'b0;
      tmo_cnt  <= '0;
    end
    else
    begin
      start_lo <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        IDLE:
          if (accept)
          begin
            state    <= SEND_LO;
            cmd_rdy  <= 1'b0;
            start_lo <= 1'b1;
          end
        SEND_LO:
          if (link.tx_done)
            state <= SEND_HI;
        SEND_HI:
          if (link.tx_done)
          begin
            if (cmd_q[RW_BIT])
            begin
              state   <= IDLE;  // write done.
              cmd_rdy <= 1'b1;
            end
            else
            begin
              state    <= WAIT_RESP;
              rx_arm_q <= 1'b1;
              tmo_cnt  <= '0;
            end
          end
        WAIT_RESP:
          if (link.rx_busy)
            state <= RECV;
          else if (timeout_hit)
          begin
            state    <= REPORT;
            read_rdy <= 1'b1;
            rx_arm_q <= 1'b0;
          end
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        RECV:
          if (resp_done)
          begin
            state    <= REPORT;
            read_rdy <= 1'b1;
            rx_arm_q <= 1'b0;
          end
          else if (!link.rx_busy)
            state <= WAIT_RESP;  // false start, keep waiting.
        REPORT:
        begin
          state   <= IDLE;
          cmd_rdy <= 1'b1;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (timeout_hit)
    begin
      read_data <= '0;
      read_err  <= 1'b1;
    end
    else if (resp_done)
    begin
      read_data <= link.rx_data;
      read_err  <= link.rx_err;
    end
  end

  a_rdy_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && read_rdy));

  a_arm_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    link.rx_arm |-> (state inside {WAIT_RESP, RECV}));

endmodule

// ==== logic/uart_cmd_master.sv ====
module uart_cmd_master import uart_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       rx,
  output logic       tx,
  output data_byte_t read_data,
  output logic       read_rdy,
  output logic       read_err
);

  // byte transfers between the sequencer and both line engines.
  serial_byte_if link ();

  // ------------------------------------------------------------------
  // line engines
  // ------------------------------------------------------------------
  uart_tx_framer u_tx_framer (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link.tx),
    .tx    (tx)
  );

  uart_rx_deframer u_rx_deframer (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link.rx),
    .rx    (rx)
  );

  // ------------------------------------------------------------------
  // command control
  // ------------------------------------------------------------------
  cmd_sequencer u_cmd_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .link      (link.seq)
  );

endmodule

// ==== tests/uart_cmd_checker.sv ====
module uart_cmd_checker import uart_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx,
  input  logic       cmd_rdy,
  input  logic       read_rdy,
  input  data_byte_t read_data,
  input  logic       read_err,
  input  logic       test_start,
  input  logic       test_end,
  input  logic       all_done,
  input  cmd_word_t  exp_cmd,
  input  logic       exp_resp,
  input  logic       exp_bad,
  input  data_byte_t exp_byte,
  output int         error_count
);

  int dec_errs = 0;
  int cmp_errs = 0;
  int frame_total = 0;
  int frame_base = 0;
  int reads = 0;
  int errs_at_start = 0;
  int test_idx = 0;
  int passed = 0;

  assign error_count = dec_errs + cmp_errs;

  task automatic show_mismatch(input string msg);
    $display("MISMATCH @ %0t: %s", $time, msg);
  endtask

  // ------------------------------------------------------------------
  // tx frame decoder sampling at mid-bit
  // ------------------------------------------------------------------
  initial
  begin : decode_tx
    data_byte_t got;
    data_byte_t want;
    logic       par_bit;
    logic       stop_bit;
    @(posedge rst_n);
    @(negedge clk);
    if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0)
    begin
      show_mismatch($sformatf("reset state tx=%b cmd_rdy=%b read_rdy=%b",
                              tx, cmd_rdy, read_rdy));
      dec_errs++;
    end
    forever
    begin
      @(negedge tx);
      repeat (HALF_BIT) @(negedge clk);
      if (tx !== 1'b0)
      begin
        show_mismatch("start bit not low at mid-bit");
        dec_errs++;
      end
      for (int b = 0; b < DATA_W; b++)
      begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        got[b] = tx;  // lsb first.
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      par_bit = tx;
      repeat (CLKS_PER_BIT) @(negedge clk);
      stop_bit = tx;
      want = (frame_total == frame_base) ? exp_cmd[DATA_W-1:0] : exp_cmd[CMD_W-1:DATA_W];
      if (frame_total - frame_base >= 2)
      begin
        show_mismatch($sformatf("extra frame %h on tx", got));
        dec_errs++;
      end
      else if (got !== want)
      begin
        show_mismatch($sformatf("tx byte %h, expected %h", got, want));
        dec_errs++;
      end
      if ((^{got, par_bit}) !== 1'b1 || stop_bit !== 1'b1)
      begin
        show_mismatch($sformatf("byte %h parity %b stop %b", got, par_bit, stop_bit));
        dec_errs++;
      end
      frame_total++;
    end
  end

  // ------------------------------------------------------------------
  // read results and per-test summary
  // ------------------------------------------------------------------
  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      reads++;
      if (exp_cmd[RW_BIT])
      begin
        show_mismatch("read_rdy after a write");
        cmp_errs++;
      end
      else if (!exp_resp && (read_data !== '0 || read_err !== 1'b1))
      begin
        show_mismatch($sformatf("timeout gave data %h err %b", read_data, read_err));
        cmp_errs++;
      end
      else if (exp_resp && exp_bad && read_err !== 1'b1)
      begin
        show_mismatch("bad parity response not flagged");
        cmp_errs++;
      end
      else if (exp_resp && !exp_bad && (read_data !== exp_byte || read_err !== 1'b0))
      begin
        show_mismatch($sformatf("read data %h err %b, expected %h err 0",
                                read_data, read_err, exp_byte));
        cmp_errs++;
      end
    end
    if (test_start)
    begin
      frame_base    = frame_total;
      reads         = 0;
      errs_at_start = dec_errs + cmp_errs;
    end
    if (test_end)
    begin
      if (frame_total - frame_base != 2)
      begin
        show_mismatch($sformatf("%0d frames, expected 2", frame_total - frame_base));
        cmp_errs++;
      end
      if (reads != (exp_cmd[RW_BIT] ? 0 : 1))
      begin
        show_mismatch($sformatf("%0d read_rdy pulses", reads));
        cmp_errs++;
      end
      if (dec_errs + cmp_errs == errs_at_start)
        passed++;
      $display("test %0d cmd %h: %s", test_idx, exp_cmd,
               (dec_errs + cmp_errs == errs_at_start) ? "ok" : "errors");
      test_idx++;
    end
    if (all_done)
      $display("%0d tests, %0d ok, %0d with errors, %0d mismatches",
               test_idx, passed, test_idx - passed, dec_errs + cmp_errs);
  end

endmodule

// ==== tests/tb_uart_cmd_master.sv ====
module tb_uart_cmd_master import uart_cmd_pkg::*; ();

  localparam int NTESTS     = 6;
  localparam int SEED       = 12171;
  localparam int MAX_CYCLES = NTESTS * (33 * CLKS_PER_BIT + RESP_TIMEOUT + 100);

  logic       clk;
  logic       rst_n;
  cmd_word_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  data_byte_t read_data;
  logic       read_rdy;
  logic       read_err;

  logic       test_start;
  logic       test_end;
  logic       all_done;
  cmd_word_t  exp_cmd;
  logic       exp_resp;
  logic       exp_bad;
  data_byte_t exp_byte;
  int         error_count;

  // stimulus table with one entry per test.
  cmd_word_t  tbl_cmd  [NTESTS];
  logic       tbl_resp [NTESTS];  // responder answers.
  logic       tbl_bad  [NTESTS];  // answer with wrong parity.
  logic       tbl_poke [NTESTS];  // extra cmd_vld while busy.
  data_byte_t tbl_byte [NTESTS];
  int         seed;
  int         cycles;

  initial
    clk = 1'b0;
  always #4 clk = ~clk;

  task automatic set_entry(input int i, input cmd_word_t c, input logic resp,
                           input logic bad, input logic poke);
    tbl_cmd[i]  = c;
    tbl_resp[i] = resp;
    tbl_bad[i]  = bad;
    tbl_poke[i] = poke;
  endtask

  task automatic fill_table();
    seed = SEED;
    set_entry(0, 16'h93C5, 1'b0, 1'b0, 1'b0);  // write.
    set_entry(1, 16'h1234, 1'b1, 1'b0, 1'b0);  // read with a good answer.
    set_entry(2, 16'h2A7E, 1'b1, 1'b1, 1'b0);  // read with bad parity.
    set_entry(3, 16'h0F0F, 1'b0, 1'b0, 1'b0);  // read with no answer.
    set_entry(4, 16'hC3A1, 1'b0, 1'b0, 1'b1);
    set_entry(5, 16'h5D18, 1'b1, 1'b0, 1'b1);
    for (int i = 0; i < NTESTS; i++)
      tbl_byte[i] = data_byte_t'($random(seed));
  endtask

  // remote side answers three bit times after the second stop bit.
  task automatic send_response(input data_byte_t b, input logic bad);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ bad, b, 1'b0};
    repeat (25 * CLKS_PER_BIT) @(posedge clk);
    for (int k = 0; k < 11; k++)
    begin
      #1 rx = frame[k];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  task automatic poke_busy(input cmd_word_t c);
    repeat (4 * CLKS_PER_BIT) @(posedge clk);
    #1 cmd_in = ~c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1 cmd_vld = 1'b0;
  endtask

  task automatic run_test(input int i);
    @(posedge clk);
    #1 exp_cmd = tbl_cmd[i];
    exp_resp   = tbl_resp[i];
    exp_bad    = tbl_bad[i];
    exp_byte   = tbl_byte[i];
    cmd_in     = tbl_cmd[i];
    cmd_vld    = 1'b1;
    test_start = 1'b1;
    @(posedge clk);  // cmd_rdy is high so this edge accepts.
    #1 cmd_vld = 1'b0;
    test_start = 1'b0;
    fork
      if (tbl_poke[i])
        poke_busy(tbl_cmd[i]);
      if (!tbl_cmd[i][RW_BIT] && tbl_resp[i])
        send_response(tbl_byte[i], tbl_bad[i]);
    join
    do
      @(negedge clk);
    while (cmd_rdy !== 1'b1);
    @(posedge clk);
    #1 test_end = 1'b1;
    @(posedge clk);
    #1 test_end = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial
  begin
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    rx         = 1'b1;
    test_start = 1'b0;
    test_end   = 1'b0;
    all_done   = 1'b0;
    exp_cmd    = '0;
    exp_resp   = 1'b0;
    exp_bad    = 1'b0;
    exp_byte   = '0;
    fill_table();
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < NTESTS; i++)
      run_test(i);
    @(posedge clk);
    #1 all_done = 1'b1;
    @(posedge clk);
    #1 all_done = 1'b0;
    if (error_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  uart_cmd_master u_uart_cmd_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_cmd_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .cmd_rdy     (cmd_rdy),
    .read_rdy    (read_rdy),
    .read_data   (read_data),
    .read_err    (read_err),
    .test_start  (test_start),
    .test_end    (test_end),
    .all_done    (all_done),
    .exp_cmd     (exp_cmd),
    .exp_resp    (exp_resp),
    .exp_bad     (exp_bad),
    .exp_byte    (exp_byte),
    .error_count (error_count)
  );

endmodule

// ==== build.f ====
logic/uart_cmd_pkg.sv
logic/serial_byte_if.sv
logic/uart_tx_framer.sv
logic/uart_rx_deframer.sv
logic/cmd_sequencer.sv
logic/uart_cmd_master.sv
tests/uart_cmd_checker.sv
tests/tb_uart_cmd_master.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_uart_cmd_master
RTL_TOP   := uart_cmd_master
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
